// ==== filelist.f ====
hw/dout_pkg.sv
hw/dout_pwm_channel.sv
hw/waveform_table_ram.sv
hw/waveform_player.sv
hw/dout_cfg_detect.sv
hw/dout_ctrl.sv
tests/dout_ctrl_assert.sv
tests/tb_dout_ctrl.sv

// ==== hw/dout_cfg_detect.sv ====
// ==============================
// output hardware detection
// debounces the two direction-sense pins,
// flags bidirectional boards and drives their direction lines
// ==============================
`timescale 1ns/1ps
`default_nettype none

module dout_cfg_detect (
    input  logic sysclk,
    input  logic dout_cfg_reset,
    input  logic dir12_read,
    input  logic dir34_read,
    output logic cfg_valid,
    output logic cfg_bidir,
    output logic dir12_reg,
    output logic dir34_reg
);

    dout_pkg::cfg_state_e state;

    logic [11:0] stable_cnt;   // consecutive steady samples
    logic        samp12;       // previous pin samples
    logic        samp34;
    logic        pins_steady;
    logic        new_board;    // pull-downs on the sense pins read low

    // both pins agree and neither moved since last sample
    assign pins_steady = (dir12_read == dir34_read) &&
                         (dir12_read == samp12) &&
                         (dir34_read == samp34);
    assign new_board = ~(dir12_read | dir34_read);

    assign cfg_valid = (state == dout_pkg::CFG_DONE);

    always_ff @(posedge sysclk) begin
        if (dout_cfg_reset) begin
            state      <= dout_pkg::CFG_SAMPLE;
            stable_cnt <= '0;
            samp12     <= 1'b0;
            samp34     <= 1'b0;
            cfg_bidir  <= 1'b0;
            dir12_reg  <= 1'b0;  // tri-state direction lines until known
            dir34_reg  <= 1'b0;
        end else if (state == dout_pkg::CFG_SAMPLE) begin
            samp12 <= dir12_read;
            samp34 <= dir34_read;
            if (!pins_steady) begin
                stable_cnt <= '0;  // glitch or disagreement, start over
            end else if (stable_cnt == dout_pkg::CFG_CNT_MAX) begin
                state     <= dout_pkg::CFG_DONE;
                cfg_bidir <= new_board;
                dir12_reg <= new_board;  // transceiver boards get driven
                dir34_reg <= new_board;
            end else begin
                stable_cnt <= stable_cnt + 12'd1;
            end
        end
        // CFG_DONE holds until the next reset
    end

endmodule

`default_nettype wire

// ==== hw/dout_ctrl.sv ====
// ==============================
// digital output controller top level
// write decode, control word read mux,
// table address mux, output mux, status word
// four channels, table RAM, player, config detector
// ==============================
`timescale 1ns/1ps
`default_nettype none

module dout_ctrl (
    input  logic                   sysclk,
    input  logic                   dout_cfg_reset,
    input  dout_pkg::reg_wr_t      reg_wr,
    input  logic [15:0]            reg_raddr,
    output logic [31:0]            reg_rdata,
    output logic [31:0]            table_rdata,
    output dout_pkg::dout_status_t dout,
    input  logic                   dir12_read,
    input  logic                   dir34_read,
    output logic                   dir12_reg,
    output logic                   dir34_reg,
    output logic                   dout_cfg_valid,
    output logic                   dout_cfg_bidir
);

    dout_pkg::wr_kind_e wr_kind;

    dout_pkg::dout_ctrl_word_t ctrl_word [dout_pkg::NUM_DOUT];  // per-channel registers
    logic [dout_pkg::NUM_DOUT-1:0] pwm_level;                   // channel outputs

    dout_pkg::table_entry_t        table_entry;  // registered RAM word
    logic [dout_pkg::TABLE_AW-1:0] ram_raddr;
    logic [dout_pkg::TABLE_AW-1:0] wave_addr;
    logic [3:0]                    wave_mask;
    logic                          wave_active;
    logic                          wave_start;   // restart with table enable

    logic [3:0] wr_sel;   // channel field of the write address
    logic [3:0] wr_off;   // register offset of the write address

    assign wr_sel = reg_wr.waddr[7:4];
    assign wr_off = reg_wr.waddr[3:0];

    // classify the strobe, at most one kind per cycle
    always_comb begin
        wr_kind = dout_pkg::WR_NONE;
        if (reg_wr.wen) begin
            if (reg_wr.waddr[15:12] == dout_pkg::ADDR_WAVEFORM) begin
                wr_kind = dout_pkg::WR_TABLE;
            end else if (reg_wr.waddr[15:12] == dout_pkg::ADDR_MAIN) begin
                if (wr_sel == 4'd0 && wr_off == dout_pkg::REG_DIGIOUT)
                    wr_kind = dout_pkg::WR_DIGIOUT;
                else if (wr_off == dout_pkg::OFF_DOUT_CTRL && wr_sel != 4'd0 &&
                         wr_sel <= 4'(dout_pkg::NUM_DOUT))
                    wr_kind = dout_pkg::WR_DOUT_CTRL;  // channel 1..4 only
            end
        end
    end

    genvar gi;
    generate
        for (gi = 0; gi < dout_pkg::NUM_DOUT; gi++) begin : g_chan
            dout_pwm_channel u_chan (
                .sysclk         (sysclk),
                .dout_cfg_reset (dout_cfg_reset),
                .ctrl_load      (wr_kind == dout_pkg::WR_DOUT_CTRL && wr_sel == 4'(gi + 1)),
                .set_en         (wr_kind == dout_pkg::WR_DIGIOUT && reg_wr.wdata[8 + gi]),
                .set_level      (reg_wr.wdata[gi]),
                .ctrl_wdata     (reg_wr.wdata),
                .ctrl_word      (ctrl_word[gi]),
                .level          (pwm_level[gi])
            );
        end
    endgenerate

    // control word readback, combinational on the read address
    always_comb begin
        reg_rdata = '0;
        for (int i = 0; i < dout_pkg::NUM_DOUT; i++) begin
            if (reg_raddr[3:0] == dout_pkg::OFF_DOUT_CTRL && reg_raddr[7:4] == 4'(i + 1))
                reg_rdata = ctrl_word[i];
        end
    end

    // a table-enable write fetches entry 0 right away so the first
    // entry is on the bus the cycle after the strobe
    assign wave_start = (wr_kind == dout_pkg::WR_DIGIOUT) && reg_wr.wdata[31];

    always_comb begin
        if (wave_start)
            ram_raddr = '0;
        else if (|wave_mask)
            ram_raddr = wave_addr;                        // player owns the port
        else
            ram_raddr = reg_raddr[dout_pkg::TABLE_AW-1:0];  // host readback
    end

    waveform_table_ram u_table_ram (
        .sysclk (sysclk),
        .wen    (wr_kind == dout_pkg::WR_TABLE),
        .waddr  (reg_wr.waddr[dout_pkg::TABLE_AW-1:0]),
        .wdata  (reg_wr.wdata),
        .raddr  (ram_raddr),
        .rdata  (table_entry)
    );

    assign table_rdata = table_entry;

    waveform_player u_player (
        .sysclk         (sysclk),
        .dout_cfg_reset (dout_cfg_reset),
        .restart        (wr_kind == dout_pkg::WR_DIGIOUT),
        .table_en       (reg_wr.wdata[31]),
        .mask_wdata     (reg_wr.wdata[11:8]),
        .entry          (table_entry),
        .mask           (wave_mask),
        .table_addr     (wave_addr),
        .active         (wave_active)
    );

    // output mux and status word
    always_comb begin
        dout             = '0;
        dout.wave_any    = |wave_mask;
        dout.wave_active = wave_active;
        dout.table_addr  = wave_addr;
        for (int i = 0; i < dout_pkg::NUM_DOUT; i++) begin
            // table level only for owned bits with a valid entry
            dout.bits[i] = (wave_mask[i] && table_entry.valid) ?
                           table_entry.level[i] : pwm_level[i];
        end
    end

    dout_cfg_detect u_cfg_detect (
        .sysclk         (sysclk),
        .dout_cfg_reset (dout_cfg_reset),
        .dir12_read     (dir12_read),
        .dir34_read     (dir34_read),
        .cfg_valid      (dout_cfg_valid),
        .cfg_bidir      (dout_cfg_bidir),
        .dir12_reg      (dir12_reg),
        .dir34_reg      (dir34_reg)
    );

endmodule

`default_nettype wire

// ==== hw/dout_pkg.sv ====
// ==============================
// shared definitions for the digital-output controller
// register map constants, table and detector sizes
// bus, control word, table entry and status word structs
// write decode and detector state enums
// ==============================
`default_nettype none

package dout_pkg;

    // address spaces in waddr[15:12]
    localparam logic [3:0] ADDR_MAIN     = 4'h0;
    localparam logic [3:0] ADDR_WAVEFORM = 4'h8;

    // register offsets in waddr[3:0]
    localparam logic [3:0] REG_DIGIOUT   = 4'h6;  // channel field must be 0
    localparam logic [3:0] OFF_DOUT_CTRL = 4'h9;  // channel 1..4 in waddr[7:4]

    localparam int NUM_DOUT    = 4;
    localparam int TABLE_AW    = 10;
    localparam int TABLE_DEPTH = 1 << TABLE_AW;   // 1024 entries

    // stable samples needed by the config detector, minus one
    localparam logic [11:0] CFG_CNT_MAX = 12'hfff;

    // single-cycle write strobe from the host interface
    typedef struct packed {
        logic [15:0] waddr;
        logic [31:0] wdata;
        logic        wen;
    } reg_wr_t;

    // per-channel control word, zero time means hold forever
    typedef struct packed {
        logic [15:0] high_time;
        logic [15:0] low_time;
    } dout_ctrl_word_t;

    // one waveform table word
    typedef struct packed {
        logic        valid;    // 0 terminates playback
        logic [22:0] end_cnt;  // entry lasts end_cnt+2 clocks incl. fetch
        logic [3:0]  pad;
        logic [3:0]  level;    // output levels for bits 3:0
    } table_entry_t;

    // dout status port
    typedef struct packed {
        logic        wave_any;     // bit 31, some bit owned by the table
        logic        wave_active;  // bit 30, owned and entry valid
        logic [3:0]  pad_hi;       // 29:26
        logic [9:0]  table_addr;   // 25:16
        logic [11:0] pad_lo;       // 15:4
        logic [3:0]  bits;         // 3:0
    } dout_status_t;

    typedef enum logic [1:0] {
        WR_NONE,
        WR_DIGIOUT,
        WR_DOUT_CTRL,
        WR_TABLE
    } wr_kind_e;

    typedef enum logic {
        CFG_SAMPLE,
        CFG_DONE
    } cfg_state_e;

endpackage

`default_nettype wire

// ==== hw/dout_pwm_channel.sv ====
// ==============================
// one digital output bit
// control register (high/low times), hold timer,
// direct set and toggle logic for one-shot and PWM
// ==============================
`timescale 1ns/1ps
`default_nettype none

module dout_pwm_channel (
    input  logic                      sysclk,
    input  logic                      dout_cfg_reset,
    input  logic                      ctrl_load,   // write control word
    input  logic                      set_en,      // force level to set_level
    input  logic                      set_level,
    input  dout_pkg::dout_ctrl_word_t ctrl_wdata,
    output dout_pkg::dout_ctrl_word_t ctrl_word,
    output logic                      level
);

    logic [15:0] hold_cnt;   // clocks spent at the current level
    logic [15:0] hold_time;  // time selected by the current level

    // high level runs on high_time, low level on low_time
    assign hold_time = level ? ctrl_word.high_time : ctrl_word.low_time;

    always_ff @(posedge sysclk) begin
        if (dout_cfg_reset) begin
            ctrl_word <= '0;
            level     <= 1'b0;
            hold_cnt  <= '0;
        end else begin
            if (ctrl_load)
                ctrl_word <= ctrl_wdata;

            if (set_en) begin
                level    <= set_level;  // direct write always wins
                hold_cnt <= '0;
            end else if (ctrl_load) begin
                hold_cnt <= '0;         // new times, start counting again
            end else if (hold_time != 16'd0) begin
                // level held for hold_time+1 clocks, then inverted
                if (hold_cnt >= hold_time) begin
                    level    <= ~level;
                    hold_cnt <= '0;
                end else begin
                    hold_cnt <= hold_cnt + 16'd1;
                end
            end
            // zero time: level and timer stay put
        end
    end

endmodule

`default_nettype wire

// ==== hw/waveform_player.sv ====
// ==============================
// waveform table sequencer
// channel mask, table read address,
// per-entry hold counter and fetch wait
// ==============================
`timescale 1ns/1ps
`default_nettype none

module waveform_player (
    input  logic                          sysclk,
    input  logic                          dout_cfg_reset,
    input  logic                          restart,     // digital output write
    input  logic                          table_en,    // wdata[31] of that write
    input  logic [3:0]                    mask_wdata,  // bits handed to the table
    input  dout_pkg::table_entry_t        entry,       // registered RAM output
    output logic [3:0]                    mask,
    output logic [dout_pkg::TABLE_AW-1:0] table_addr,
    output logic                          active
);

    logic [22:0] entry_cnt;  // clocks counted on the current entry
    logic        fetch;      // new address issued, entry not yet on the bus
    logic        running;

    assign running = |mask;

    // during fetch the bus still carries the previous valid entry
    assign active = running && entry.valid;

    always_ff @(posedge sysclk) begin
        if (dout_cfg_reset) begin
            mask       <= '0;
            table_addr <= '0;
            entry_cnt  <= '0;
            fetch      <= 1'b0;
        end else if (restart) begin
            // entry 0 is read in the restart cycle, so no fetch wait here
            mask       <= table_en ? mask_wdata : 4'd0;
            table_addr <= '0;
            entry_cnt  <= '0;
            fetch      <= 1'b0;
        end else if (running && fetch) begin
            fetch <= 1'b0;             // next entry lands on this edge
        end else if (active) begin
            if (entry_cnt == entry.end_cnt) begin
                table_addr <= table_addr + 1'b1;
                entry_cnt  <= '0;
                fetch      <= 1'b1;
            end else begin
                entry_cnt <= entry_cnt + 23'd1;
            end
        end else begin
            // idle, or end of table reached
            mask       <= '0;
            table_addr <= '0;
            entry_cnt  <= '0;
            fetch      <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/waveform_table_ram.sv ====
// ==============================
// waveform table storage
// 1024 x 32 simple dual-port RAM,
// write port plus registered read port
// ==============================
`timescale 1ns/1ps
`default_nettype none

module waveform_table_ram (
    input  logic                          sysclk,
    input  logic                          wen,
    input  logic [dout_pkg::TABLE_AW-1:0] waddr,
    input  logic [31:0]                   wdata,
    input  logic [dout_pkg::TABLE_AW-1:0] raddr,
    output dout_pkg::table_entry_t        rdata
);

    logic [31:0] mem [0:dout_pkg::TABLE_DEPTH-1];  // host pattern data

    always_ff @(posedge sysclk) begin
        if (wen)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];  // one clock read latency, old data on collision
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the digital-output controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_dout_ctrl -o tb_dout_ctrl

if ! out=$(./obj_dir/tb_dout_ctrl 2>&1); then
    echo "$out"
    echo "simulation exited with an error"
    exit 1
fi
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS"

// ==== tests/dout_ctrl_assert.sv ====
// ==============================
// concurrent checks bound to the top level
// write decode, end of table, config valid
// ==============================
`timescale 1ns/1ps
`default_nettype none

module dout_ctrl_assert (
    input logic                             sysclk,
    input logic                             dout_cfg_reset,
    input dout_pkg::wr_kind_e               wr_kind,
    input logic [dout_pkg::NUM_DOUT*32-1:0] ctrl_words,  // all control registers
    input logic [3:0]                       wave_mask,
    input logic                             entry_valid,
    input logic                             cfg_valid
);

    // a strobe of any other kind never lands in a control register
    decode_one_kind: assert property (@(posedge sysclk) disable iff (dout_cfg_reset)
        (wr_kind != dout_pkg::WR_DOUT_CTRL) |=> $stable(ctrl_words))
        else $error("control word changed without a control word write");

    // an invalid entry ends playback unless a new restart comes in
    mask_clear_at_end: assert property (@(posedge sysclk) disable iff (dout_cfg_reset)
        (|wave_mask && !entry_valid && wr_kind != dout_pkg::WR_DIGIOUT) |=> wave_mask == 4'h0)
        else $error("player mask still set after an invalid entry");

    cfg_valid_held: assert property (@(posedge sysclk)
        $fell(cfg_valid) |-> $past(dout_cfg_reset))
        else $error("dout_cfg_valid fell without a reset");

endmodule

bind dout_ctrl dout_ctrl_assert u_assert (
    .sysclk(sysclk), .dout_cfg_reset(dout_cfg_reset), .wr_kind(wr_kind),
    .ctrl_words({ctrl_word[3], ctrl_word[2], ctrl_word[1], ctrl_word[0]}),
    .wave_mask(wave_mask), .entry_valid(table_entry.valid),
    .cfg_valid(dout_cfg_valid)
);

`default_nettype wire

// ==== tests/tb_dout_ctrl.sv ====
// ==============================
// testbench for the digital-output controller
// clock, reset, LCG, bus tasks, reference model,
// per-cycle dout comparison, watchdog, result line
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_dout_ctrl;

    logic                   sysclk = 1'b0;
    logic                   dout_cfg_reset;
    dout_pkg::reg_wr_t      reg_wr;
    logic [15:0]            reg_raddr;
    logic [31:0]            reg_rdata;
    logic [31:0]            table_rdata;
    dout_pkg::dout_status_t dout;
    logic                   dir12_read;
    logic                   dir34_read;
    logic                   dir12_reg;
    logic                   dir34_reg;
    logic                   dout_cfg_valid;
    logic                   dout_cfg_bidir;

    logic [31:0]               lcg_state = 32'he7a0;
    logic [31:0]               tbl [16];   // copy of the table entries written
    logic [3:0]                m_start;    // channel level at its last timer restart
    dout_pkg::dout_ctrl_word_t m_cw [4];
    int                        m_n [4];    // edges since that restart
    logic [3:0]                w_mask;     // expected table ownership
    int                        w_idx;
    int                        w_age;
    int                        checks = 0;
    int                        val_errs = 0;
    int                        other_errs = 0;

    always #4 sysclk = ~sysclk;  // 8 ns period

    dout_ctrl dut (
        .sysclk(sysclk), .dout_cfg_reset(dout_cfg_reset), .reg_wr(reg_wr),
        .reg_raddr(reg_raddr), .reg_rdata(reg_rdata), .table_rdata(table_rdata),
        .dout(dout), .dir12_read(dir12_read), .dir34_read(dir34_read),
        .dir12_reg(dir12_reg), .dir34_reg(dir34_reg),
        .dout_cfg_valid(dout_cfg_valid), .dout_cfg_bidir(dout_cfg_bidir)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [15:0] dig_addr();
        return {dout_pkg::ADDR_MAIN, 8'h00, dout_pkg::REG_DIGIOUT};
    endfunction

    function automatic logic [15:0] ctl_addr(input int ch);
        return {dout_pkg::ADDR_MAIN, 4'h0, 4'(ch), dout_pkg::OFF_DOUT_CTRL};
    endfunction

    // each level lasts its time+1 cycles and a zero time holds it forever
    function automatic logic chan_ref(input logic start, input dout_pkg::dout_ctrl_word_t cw,
                                      input int n);
        logic lvl;
        int   t;
        lvl = start;
        t   = lvl ? int'(cw.high_time) : int'(cw.low_time);
        while (t != 0 && n > t) begin
            n   = n - (t + 1);
            lvl = ~lvl;
            t   = lvl ? int'(cw.high_time) : int'(cw.low_time);
        end
        return lvl;
    endfunction

    // expected status word for the current cycle
    function automatic dout_pkg::dout_status_t dout_ref();
        dout_pkg::dout_status_t s;
        dout_pkg::table_entry_t e;
        s = '0;
        e = tbl[w_idx];
        for (int i = 0; i < 4; i++)
            s.bits[i] = chan_ref(m_start[i], m_cw[i], m_n[i]);
        if (w_mask != 4'h0) begin
            s.wave_any    = 1'b1;
            s.wave_active = e.valid;
            // next address goes out one cycle before its entry arrives
            s.table_addr  = (e.valid && w_age == int'(e.end_cnt) + 1) ? 10'(w_idx + 1)
                                                                        : 10'(w_idx);
            for (int i = 0; i < 4; i++)
                if (w_mask[i] && e.valid)
                    s.bits[i] = e.level[i];
        end
        return s;
    endfunction

    task automatic model_clear();
        m_start = '0;
        for (int i = 0; i < 4; i++) begin
            m_cw[i] = '0;
            m_n[i]  = 0;
        end
        w_mask = '0;
        w_idx  = 0;
        w_age  = 0;
    endtask

    // advance the model by the strobe the DUT takes at the next edge
    task automatic model_step();
        dout_pkg::table_entry_t e;
        logic is_dig, is_ctl;
        is_dig = reg_wr.wen && reg_wr.waddr == dig_addr();
        is_ctl = reg_wr.wen && reg_wr.waddr[15:12] == dout_pkg::ADDR_MAIN &&
                 reg_wr.waddr[3:0] == dout_pkg::OFF_DOUT_CTRL;
        for (int i = 0; i < 4; i++) begin
            if (is_dig && reg_wr.wdata[8+i]) begin
                m_start[i] = reg_wr.wdata[i];
                m_n[i]     = 0;
            end else if (is_ctl && reg_wr.waddr[7:4] == 4'(i + 1)) begin
                m_start[i] = chan_ref(m_start[i], m_cw[i], m_n[i]);  // level kept
                m_cw[i]    = reg_wr.wdata;
                m_n[i]     = 0;
            end else begin
                m_n[i]++;
            end
        end
        e = tbl[w_idx];
        if (is_dig) begin
            w_mask = reg_wr.wdata[31] ? reg_wr.wdata[11:8] : 4'h0;
            w_idx  = 0;
            w_age  = 0;
        end else if (w_mask != 4'h0) begin
            if (!e.valid) begin
                w_mask = '0;  // end of table
            end else begin
                w_age++;
                if (w_age == int'(e.end_cnt) + 2) begin
                    w_idx++;
                    w_age = 0;
                end
            end
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            val_errs++;
            $display("ERR %s exp %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    always @(negedge sysclk) begin : compare
        if (dout_cfg_reset) begin
            model_clear();
        end else begin
            check_val("dout", dout, dout_ref());
            model_step();
        end
    end

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge sysclk);
        reg_wr <= '{waddr: addr, wdata: data, wen: 1'b1};
        @(posedge sysclk);
        reg_wr <= '0;
    endtask

    task automatic apply_reset(input logic pins);
        @(posedge sysclk);
        dout_cfg_reset <= 1'b1;
        dir12_read     <= pins;
        dir34_read     <= pins;
        repeat (10) @(posedge sysclk);
        dout_cfg_reset <= 1'b0;
    endtask

    // wait for cfg_valid with an optional one-cycle glitch on dir12
    task automatic wait_cfg(input int glitch_at, input int n_min, input logic bidir);
        int n;
        n = 0;
        while (n < n_min + 100) begin
            @(posedge sysclk);
            n++;
            if (glitch_at > 0 && (n == glitch_at || n == glitch_at + 1))
                dir12_read <= ~dir12_read;
            @(negedge sysclk);
            if (dout_cfg_valid) break;
        end
        assert (dout_cfg_valid && n >= n_min && n <= n_min + 3) else begin
            other_errs++;
            $display("cfg_valid took %0d cycles, wanted %0d to %0d", n, n_min, n_min + 3);
        end
        check_val("dout_cfg_bidir", dout_cfg_bidir, bidir);
        check_val("dir12_reg", dir12_reg, bidir);
        check_val("dir34_reg", dir34_reg, bidir);
    endtask

    task automatic count_high(input int cycles, output int n);
        n = 0;
        repeat (cycles) begin
            @(negedge sysclk);
            if (dout.bits[0]) n++;
        end
    endtask

    task automatic read_ctrl(input int ch, input logic [31:0] exp);
        @(posedge sysclk);
        reg_raddr <= ctl_addr(ch);
        @(negedge sysclk);
        check_val("reg_rdata", reg_rdata, exp);  // combinational readback
    endtask

    initial begin : stimulus
        int          n;
        int          t;
        logic [31:0] r;
        logic [31:0] w;
        logic [3:0]  mask;
        dout_cfg_reset = 1'b1;
        reg_wr         = '0;
        reg_raddr      = '0;
        dir12_read     = 1'b0;
        dir34_read     = 1'b0;
        for (int k = 0; k < 16; k++)
            tbl[k] = '0;

        // config detection on a transceiver board, a plain board and with a glitch
        apply_reset(1'b0);
        wait_cfg(0, int'(dout_pkg::CFG_CNT_MAX) + 1, 1'b1);
        apply_reset(1'b1);
        wait_cfg(0, int'(dout_pkg::CFG_CNT_MAX) + 1, 1'b0);
        apply_reset(1'b0);
        wait_cfg(2000, 2002 + int'(dout_pkg::CFG_CNT_MAX) + 1, 1'b1);

        // set/clear with random masks
        repeat (20) begin
            r = lcg_next();
            bus_write(dig_addr(), r & 32'h0000_0f0f);
        end

        // one-shot on channel 1 and a rewrite mid-pulse
        t = int'(lcg_next() >> 28) + 6;
        bus_write(ctl_addr(1), {16'(t), 16'd0});
        bus_write(dig_addr(), 32'h0000_0101);
        count_high(t + 8, n);
        check_val("one-shot high cycles", n, t + 1);
        bus_write(dig_addr(), 32'h0000_0101);
        repeat (3) @(posedge sysclk);
        bus_write(dig_addr(), 32'h0000_0101);  // restarts the timer
        count_high(t + 8, n);
        check_val("restarted pulse high cycles", n, t + 1);

        // PWM on all channels with readback of every control word
        for (int ch = 1; ch <= 4; ch++) begin
            r = lcg_next();
            w = {13'h0, r[18:16], 13'h0, r[2:0]} + 32'h0001_0001;  // 1..8 each half
            bus_write(ctl_addr(ch), w);
            read_ctrl(ch, w);
        end
        bus_write(dig_addr(), 32'h0000_0f05);
        repeat (80) @(posedge sysclk);

        // waveform table terminated by an invalid entry
        for (int k = 0; k < 6; k++) begin
            r      = lcg_next();
            tbl[k] = (k == 5) ? 32'h0 : {1'b1, 20'h0, r[18:16], 4'h0, r[27:24]};
            bus_write({dout_pkg::ADDR_WAVEFORM, 12'(k)}, tbl[k]);
        end
        @(posedge sysclk);
        reg_raddr <= 16'h0002;
        @(posedge sysclk);
        @(negedge sysclk);
        check_val("table_rdata", table_rdata, tbl[2]);
        for (int p = 0; p < 2; p++) begin
            mask = (p == 0) ? 4'h6 : 4'hf;
            r    = lcg_next();
            bus_write(dig_addr(), {1'b1, 19'h0, mask, 4'h0, r[3:0]});
            n = 0;
            do begin
                @(negedge sysclk);
                n++;
            end while (dout.wave_any && n < 400);
            assert (!dout.wave_any) else begin
                other_errs++;
                $display("table playback did not hand the outputs back to the channels");
            end
            repeat (10) @(posedge sysclk);
        end

        repeat (5) @(posedge sysclk);
        $display("checks %0d, value errors %0d, other errors %0d", checks, val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // three detector waits plus the short tests and some margin
    initial begin : watchdog
        int limit;
        limit = 4 * (3 * (int'(dout_pkg::CFG_CNT_MAX) + 1) + 4000);
        repeat (limit) @(posedge sysclk);
        $display("timeout: run still going after %0d cycles", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
